//--- fb_params.svh
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// one pixel word, 4 bits each of red, green, blue
`define FB_PIXEL_BITS 12
`define FB_COMP_BITS (`FB_PIXEL_BITS / 3)

// axi-lite bus to the frame buffer memory
`define FB_AXI_ADDR_WIDTH 20
`define FB_AXI_DATA_WIDTH 16
`define FB_AXI_STRB_WIDTH ((`FB_AXI_DATA_WIDTH + 7) / 8)

// frame geometry, address is y * width + x
`define FB_WIDTH 16
`define FB_HEIGHT 8
`define FB_DEPTH (`FB_WIDTH * `FB_HEIGHT)

`endif

//--- fb_pkg.sv
`include "fb_params.svh"

package fb_pkg;

  // one stored pixel word
  // raw is what the fill path writes, rgb is how readback splits it
  typedef union packed {
    logic [`FB_PIXEL_BITS-1:0] raw;
    struct packed {
      // red sits in the top bits
      logic [`FB_COMP_BITS-1:0] red;
      logic [`FB_COMP_BITS-1:0] green;
      logic [`FB_COMP_BITS-1:0] blue;
    } rgb;
  } pixel_t;

  // rectangle fill command
  // corner in pixels, size may run past the frame edge
  typedef struct packed {
    logic [$clog2(`FB_WIDTH)-1:0]  x0;
    logic [$clog2(`FB_HEIGHT)-1:0] y0;
    logic [$clog2(`FB_WIDTH):0]    w;
    logic [$clog2(`FB_HEIGHT):0]   h;
    pixel_t                        color;
  } rect_cmd_t;

endpackage

//--- fb_if.sv
`include "fb_params.svh"

// pixel write stream, one pixel per tvalid/tready transfer
interface pix_stream_if;
  logic                          tvalid;
  logic                          tready;
  logic [`FB_AXI_ADDR_WIDTH-1:0] addr;
  logic [`FB_PIXEL_BITS-1:0]     color;

  modport source(output tvalid, output addr, output color, input tready);
  modport sink(input tvalid, input addr, input color, output tready);
endinterface

// axi-lite, split into a write side and a read side
interface axil_if;
  // write address, write data, write response
  logic [`FB_AXI_ADDR_WIDTH-1:0] awaddr;
  logic                          awvalid;
  logic                          awready;
  logic [`FB_AXI_DATA_WIDTH-1:0] wdata;
  logic [`FB_AXI_STRB_WIDTH-1:0] wstrb;
  logic                          wvalid;
  logic                          wready;
  logic [1:0]                    bresp;
  logic                          bvalid;
  logic                          bready;

  // read address, read data
  logic [`FB_AXI_ADDR_WIDTH-1:0] araddr;
  logic                          arvalid;
  logic                          arready;
  logic [`FB_AXI_DATA_WIDTH-1:0] rdata;
  logic [1:0]                    rresp;
  logic                          rvalid;
  logic                          rready;

  modport master_wr(
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input awready, wready, bresp, bvalid
  );
  modport slave_wr(
    input awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );
  modport master_rd(output araddr, arvalid, rready, input arready, rdata, rresp, rvalid);
  modport slave_rd(input araddr, arvalid, rready, output arready, rdata, rresp, rvalid);
endinterface

//--- fb_rect_fill.sv
`include "fb_params.svh"

module fb_rect_fill
  import fb_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  rect_cmd_t    cmd,
  output logic         busy,
  output logic         done,
  pix_stream_if.source pix
);

  localparam int XW = $clog2(`FB_WIDTH);
  localparam int YW = $clog2(`FB_HEIGHT);
  localparam logic [XW:0] X_SPAN = (XW + 1)'(`FB_WIDTH);
  localparam logic [YW:0] Y_SPAN = (YW + 1)'(`FB_HEIGHT);

  // clipped size and last column/row of the incoming command
  logic [XW:0]   x_room;
  logic [XW:0]   w_clip;
  logic [XW:0]   x_end;
  logic [YW:0]   y_room;
  logic [YW:0]   h_clip;
  logic [YW:0]   y_end;
  logic          cmd_empty;
  logic          start_ok;
  logic          pix_fire;
  logic          last_col;
  logic          last_row;
  // raster walk state
  logic [XW-1:0] cur_x;
  logic [XW-1:0] x_first;
  logic [XW-1:0] x_last;
  logic [YW-1:0] cur_y;
  logic [YW-1:0] y_last;
  pixel_t        color_q;

  // room left between the corner and the frame edge
  assign x_room = X_SPAN - {1'b0, cmd.x0};
  assign y_room = Y_SPAN - {1'b0, cmd.y0};
  assign w_clip = (cmd.w > x_room) ? x_room : cmd.w;
  assign h_clip = (cmd.h > y_room) ? y_room : cmd.h;
  // only meaningful when the clipped size is nonzero
  assign x_end = {1'b0, cmd.x0} + w_clip - (XW + 1)'(1);
  assign y_end = {1'b0, cmd.y0} + h_clip - (YW + 1)'(1);
  assign cmd_empty = (w_clip == '0) || (h_clip == '0);

  // no new command in the done cycle, so done and start never overlap
  assign start_ok = start && !busy && !done;
  assign pix_fire = pix.tvalid && pix.tready;
  assign last_col = (cur_x == x_last);
  assign last_row = (cur_y == y_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start_ok) begin
        // empty rectangle finishes right away with no writes
        busy <= !cmd_empty;
        done <= cmd_empty;
      end else if (pix_fire && last_col && last_row) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) begin
      cur_x   <= cmd.x0;
      cur_y   <= cmd.y0;
      x_first <= cmd.x0;
      x_last  <= x_end[XW-1:0];
      y_last  <= y_end[YW-1:0];
      color_q <= cmd.color;
    end else if (pix_fire) begin
      // step only on an accepted pixel, wrap to the first column
      if (last_col) begin
        cur_x <= x_first;
        cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  // addr and color are registers, so they hold while tvalid waits
  assign pix.tvalid = busy;
  assign pix.addr   = `FB_AXI_ADDR_WIDTH'(cur_y * `FB_WIDTH + cur_x);
  assign pix.color  = color_q.raw;

endmodule

//--- fb_writer.sv
`include "fb_params.svh"

module fb_writer
  import fb_pkg::*;
(
  input logic        clk,
  input logic        reset,
  pix_stream_if.sink pix,
  axil_if.master_wr  axi
);

  localparam int PAD = `FB_AXI_DATA_WIDTH - `FB_PIXEL_BITS;

  // stream color taken as the raw pixel word
  pixel_t wr_pix;

  assign wr_pix.raw = pix.color;

  // purely combinational path, no state here
  // address and data go out together on every pixel
  assign axi.awvalid = pix.tvalid;
  assign axi.awaddr  = pix.addr;

  assign axi.wvalid = pix.tvalid;
  // color in the high bits, low bits zero
  assign axi.wdata  = {wr_pix.raw, {PAD{1'b0}}};
  assign axi.wstrb  = {`FB_AXI_STRB_WIDTH{1'b1}};

  // response is always taken and never looked at
  assign axi.bready = 1'b1;

  // pixel accepted only when both channels take it in the same cycle
  assign pix.tready = axi.awready & axi.wready;

endmodule

//--- sram_axil.sv
`include "fb_params.svh"

module sram_axil
  import fb_pkg::*;
(
  input logic      clk,
  input logic      reset,
  axil_if.slave_wr wr,
  axil_if.slave_rd rd
);

  localparam int IW = $clog2(`FB_DEPTH);
  localparam int PAD = `FB_AXI_DATA_WIDTH - `FB_PIXEL_BITS;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  pixel_t                        mem[`FB_DEPTH];
  logic                          bvalid_q;
  logic                          rvalid_q;
  logic [`FB_AXI_DATA_WIDTH-1:0] rdata_q;
  logic                          wr_fire;
  logic                          rd_fire;
  logic [IW-1:0]                 wr_idx;
  logic [IW-1:0]                 rd_idx;

  // address taken modulo the depth
  assign wr_idx = wr.awaddr[IW-1:0];
  assign rd_idx = rd.araddr[IW-1:0];

  // write side
  // both readys drop while a response is outstanding
  assign wr.awready = !bvalid_q;
  assign wr.wready  = !bvalid_q;
  // a write needs address and data in the same cycle
  assign wr_fire = wr.awvalid && wr.wvalid && !bvalid_q;

  assign wr.bvalid = bvalid_q;
  assign wr.bresp  = RESP_OKAY;

  // read side
  // one read in flight, and a write in this cycle wins
  assign rd.arready = !rvalid_q && !wr_fire;
  assign rd_fire    = rd.arvalid && rd.arready;

  assign rd.rvalid = rvalid_q;
  assign rd.rdata  = rdata_q;
  assign rd.rresp  = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      // response the cycle after the write
      bvalid_q <= 1'b1;
    end else if (bvalid_q && wr.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && rd.rready) begin
      // held until the master takes it
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    // pixel lives in the top bits of the data word
    if (wr_fire) begin
      mem[wr_idx].raw <= wr.wdata[`FB_AXI_DATA_WIDTH-1 -: `FB_PIXEL_BITS];
    end
    // registered read data, same layout as the write
    if (rd_fire) begin
      rdata_q <= {mem[rd_idx].raw, {PAD{1'b0}}};
    end
  end

endmodule

//--- fb_reader.sv
`include "fb_params.svh"

module fb_reader
  import fb_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         rd_req,
  input  logic [$clog2(`FB_DEPTH)-1:0] rd_addr,
  output logic                         rd_busy,
  output logic                         rd_valid,
  output logic [`FB_COMP_BITS-1:0]     rd_red,
  output logic [`FB_COMP_BITS-1:0]     rd_green,
  output logic [`FB_COMP_BITS-1:0]     rd_blue,
  axil_if.master_rd                    axi
);

  // controller states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ADDR = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  logic [1:0]                   state;
  logic [$clog2(`FB_DEPTH)-1:0] addr_q;
  pixel_t                       pix_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      case (state)
        ST_IDLE: if (rd_req) state <= ST_ADDR;
        ST_ADDR: if (axi.arready) state <= ST_DATA;
        ST_DATA: begin
          if (axi.rvalid) begin
            // one cycle pulse with the captured pixel
            rd_valid <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && rd_req) begin
      addr_q <= rd_addr;
    end
    // pixel sits in the top bits of rdata
    if (state == ST_DATA && axi.rvalid) begin
      pix_q.raw <= axi.rdata[`FB_AXI_DATA_WIDTH-1 -: `FB_PIXEL_BITS];
    end
  end

  assign rd_busy = (state != ST_IDLE);

  // valid and ready follow the state alone
  assign axi.arvalid = (state == ST_ADDR);
  assign axi.araddr  = `FB_AXI_ADDR_WIDTH'(addr_q);
  assign axi.rready  = (state == ST_DATA);

  // split the word through the rgb view
  assign rd_red   = pix_q.rgb.red;
  assign rd_green = pix_q.rgb.green;
  assign rd_blue  = pix_q.rgb.blue;

endmodule

//--- fb_top.sv
`include "fb_params.svh"

module fb_top
  import fb_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  // rectangle command
  input  logic                          start,
  input  logic [$clog2(`FB_WIDTH)-1:0]  x0,
  input  logic [$clog2(`FB_HEIGHT)-1:0] y0,
  input  logic [$clog2(`FB_WIDTH):0]    w,
  input  logic [$clog2(`FB_HEIGHT):0]   h,
  input  logic [`FB_PIXEL_BITS-1:0]     color,
  output logic                          busy,
  output logic                          done,
  // single pixel readback
  input  logic                          rd_req,
  input  logic [$clog2(`FB_DEPTH)-1:0]  rd_addr,
  output logic                          rd_busy,
  output logic                          rd_valid,
  output logic [`FB_COMP_BITS-1:0]      rd_red,
  output logic [`FB_COMP_BITS-1:0]      rd_green,
  output logic [`FB_COMP_BITS-1:0]      rd_blue
);

  rect_cmd_t cmd;

  // fill engine to writer
  pix_stream_if u_pix ();
  // one axi-lite bus per master
  axil_if u_axil_wr ();
  axil_if u_axil_rd ();

  assign cmd.x0        = x0;
  assign cmd.y0        = y0;
  assign cmd.w         = w;
  assign cmd.h         = h;
  assign cmd.color.raw = color;

  fb_rect_fill u_rect_fill (
    .clk  (clk),
    .reset(reset),
    .start(start),
    .cmd  (cmd),
    .busy (busy),
    .done (done),
    .pix  (u_pix.source)
  );

  fb_writer u_writer (
    .clk  (clk),
    .reset(reset),
    .pix  (u_pix.sink),
    .axi  (u_axil_wr.master_wr)
  );

  // frame buffer, writes from the fill path, reads from readback
  sram_axil u_sram (
    .clk  (clk),
    .reset(reset),
    .wr   (u_axil_wr.slave_wr),
    .rd   (u_axil_rd.slave_rd)
  );

  fb_reader u_reader (
    .clk     (clk),
    .reset   (reset),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_busy (rd_busy),
    .rd_valid(rd_valid),
    .rd_red  (rd_red),
    .rd_green(rd_green),
    .rd_blue (rd_blue),
    .axi     (u_axil_rd.master_rd)
  );

endmodule

//--- fb_assertions.sv
`include "fb_params.svh"

module fb_assertions (
  input logic                          clk,
  input logic                          reset,
  // memory write port
  input logic                          awvalid,
  input logic                          awready,
  input logic                          wvalid,
  input logic                          wready,
  input logic                          bvalid,
  input logic                          bready,
  // fill engine stream and control
  input logic                          tvalid,
  input logic                          tready,
  input logic [`FB_AXI_ADDR_WIDTH-1:0] addr,
  input logic [`FB_PIXEL_BITS-1:0]     color,
  input logic                          start,
  input logic                          busy,
  input logic                          done
);

  int fail_count = 0;

  // address and data are offered together and stay up together until both are taken
  a_aw_with_w: assert property (@(posedge clk) disable iff (reset)
    (awvalid || wvalid) && !(awready && wready) |=> awvalid && wvalid)
    else begin
      fail_count++;
      $error("write address and data not held together until taken");
    end

  // response is taken and cleared the next cycle
  a_b_drop: assert property (@(posedge clk) disable iff (reset) bvalid && bready |=> !bvalid)
    else begin
      fail_count++;
      $error("bvalid did not drop after bready");
    end

  // a stalled pixel holds until it is accepted
  a_pix_hold: assert property (@(posedge clk) disable iff (reset)
    tvalid && !tready |=> tvalid && $stable(addr) && $stable(color))
    else begin
      fail_count++;
      $error("pixel stream changed before its transfer");
    end

  a_done_start: assert property (@(posedge clk) disable iff (reset) start && !busy |-> !done)
    else begin
      fail_count++;
      $error("done pulsed while a start was being accepted");
    end

endmodule

// one instance sees the fill stream and the memory write port
bind fb_top fb_assertions u_fb_assertions (
  .clk    (clk),
  .reset  (reset),
  .awvalid(u_axil_wr.awvalid),
  .awready(u_axil_wr.awready),
  .wvalid (u_axil_wr.wvalid),
  .wready (u_axil_wr.wready),
  .bvalid (u_axil_wr.bvalid),
  .bready (u_axil_wr.bready),
  .tvalid (u_pix.tvalid),
  .tready (u_pix.tready),
  .addr   (u_pix.addr),
  .color  (u_pix.color),
  .start  (start),
  .busy   (busy),
  .done   (done)
);

//--- tb_fb_top.sv
`include "fb_params.svh"

module tb_fb_top;

  localparam int XW = $clog2(`FB_WIDTH);
  localparam int YW = $clog2(`FB_HEIGHT);
  localparam int AW = $clog2(`FB_DEPTH);
  localparam int PB = `FB_PIXEL_BITS;
  localparam int CB = `FB_COMP_BITS;
  // run length from the tests below
  // 21 fills at 2 cycles per pixel, 5 frame sweeps plus 14 x 8 random reads
  localparam int N_FILLS = 21;
  localparam int N_RAND_READS = 8;
  localparam int FILL_LIMIT = 2 * `FB_DEPTH + 16;
  localparam int READ_LIMIT = 16;
  localparam int N_READS = 5 * `FB_DEPTH + 14 * N_RAND_READS;
  localparam int TIMEOUT = N_FILLS * FILL_LIMIT + N_READS * 8 + 1000;

  logic          clk = 1'b0;
  logic          reset;
  logic          start;
  logic [XW-1:0] x0;
  logic [YW-1:0] y0;
  logic [XW:0]   w;
  logic [YW:0]   h;
  logic [PB-1:0] color;
  logic          busy;
  logic          done;
  logic          rd_req;
  logic [AW-1:0] rd_addr;
  logic          rd_busy;
  logic          rd_valid;
  logic [CB-1:0] rd_red;
  logic [CB-1:0] rd_green;
  logic [CB-1:0] rd_blue;

  // reference copy of the frame
  logic [PB-1:0] frame[`FB_DEPTH];
  // reads in flight, filled at issue time
  logic [PB-1:0] exp_q[$];
  int            addr_q[$];
  string         name_q[$];
  int            seed = 35901;
  int            cycles = 0;
  int            checks = 0;
  int            value_errors = 0;
  int            other_errors = 0;
  int            assert_fails = 0;

  always #20 clk = ~clk;

  fb_top u_fb_top (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .x0      (x0),
    .y0      (y0),
    .w       (w),
    .h       (h),
    .color   (color),
    .busy    (busy),
    .done    (done),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_busy (rd_busy),
    .rd_valid(rd_valid),
    .rd_red  (rd_red),
    .rd_green(rd_green),
    .rd_blue (rd_blue)
  );

  // paint one rectangle, anything past the right or bottom edge is dropped
  function automatic void draw_rect(input int rx, input int ry, input int rw, input int rh,
                                    input logic [PB-1:0] rcolor);
    int x_lim;
    int y_lim;
    x_lim = (rx + rw > `FB_WIDTH) ? `FB_WIDTH : rx + rw;
    y_lim = (ry + rh > `FB_HEIGHT) ? `FB_HEIGHT : ry + rh;
    for (int yy = ry; yy < y_lim; yy++) begin
      for (int xx = rx; xx < x_lim; xx++) begin
        frame[yy * `FB_WIDTH + xx] = rcolor;
      end
    end
  endfunction

  // red from the top bits, then green, then blue
  function automatic logic [PB-1:0] expected_rgb(input int addr);
    logic [CB-1:0] r;
    logic [CB-1:0] g;
    logic [CB-1:0] b;
    r = frame[addr][PB-1 -: CB];
    g = frame[addr][PB-CB-1 -: CB];
    b = frame[addr][CB-1:0];
    return {r, g, b};
  endfunction

  // one command, then wait for its done pulse
  task automatic run_fill(input int fx, input int fy, input int fw, input int fh,
                          input logic [PB-1:0] fcolor, input string name);
    int waited;
    bit got;
    bit exp_busy;
    draw_rect(fx, fy, fw, fh, fcolor);
    // the corner is always inside the frame, so only a zero size leaves nothing to draw
    exp_busy = (fw > 0) && (fh > 0);
    @(posedge clk);
    start <= 1'b1;
    x0    <= XW'(fx);
    y0    <= YW'(fy);
    w     <= (XW + 1)'(fw);
    h     <= (YW + 1)'(fh);
    color <= fcolor;
    @(posedge clk);
    start <= 1'b0;
    waited = 0;
    got = 1'b0;
    while (!got && waited < FILL_LIMIT) begin
      @(posedge clk);
      waited++;
      // busy shows up the cycle after the command is latched
      if (waited == 1 && busy !== exp_busy) begin
        value_errors++;
        $display("FAIL %s busy expected %b actual %b", name, exp_busy, busy);
      end
      if (done) begin
        got = 1'b1;
        if (busy !== 1'b0) begin
          value_errors++;
          $display("FAIL %s busy at done expected 0 actual %b", name, busy);
        end
      end
    end
    if (!got) begin
      other_errors++;
      $display("%s: no done pulse within %0d cycles", name, FILL_LIMIT);
    end
  endtask

  // one readback, the comparison process checks the data
  task automatic read_pixel(input int addr, input string name);
    int waited;
    bit got;
    exp_q.push_back(expected_rgb(addr));
    addr_q.push_back(addr);
    name_q.push_back(name);
    @(posedge clk);
    rd_req  <= 1'b1;
    rd_addr <= AW'(addr);
    @(posedge clk);
    rd_req <= 1'b0;
    waited = 0;
    got = 1'b0;
    while (!got && waited < READ_LIMIT) begin
      @(posedge clk);
      waited++;
      // request taken, reader out of idle
      if (waited == 1 && rd_busy !== 1'b1) begin
        value_errors++;
        $display("FAIL %s rd_busy expected 1 actual %b", name, rd_busy);
      end
      if (rd_valid) begin
        got = 1'b1;
        if (rd_busy !== 1'b0) begin
          value_errors++;
          $display("FAIL %s rd_busy at rd_valid expected 0 actual %b", name, rd_busy);
        end
      end
    end
    if (!got) begin
      other_errors++;
      $display("%s: no rd_valid for the read of address %0d", name, addr);
      // drop the stale entry so later reads stay aligned
      void'(exp_q.pop_back());
      void'(addr_q.pop_back());
      void'(name_q.pop_back());
    end
  endtask

  task automatic check_frame(input string name);
    for (int a = 0; a < `FB_DEPTH; a++) begin
      read_pixel(a, name);
    end
  endtask

  // compare every rd_valid against the entry queued at issue
  always @(posedge clk) begin
    logic [PB-1:0] exp_pix;
    logic [PB-1:0] got_pix;
    int            exp_addr;
    string         exp_name;
    if (!reset && rd_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("rd_valid arrived with no read outstanding");
      end else begin
        exp_pix  = exp_q.pop_front();
        exp_addr = addr_q.pop_front();
        exp_name = name_q.pop_front();
        got_pix  = {rd_red, rd_green, rd_blue};
        checks++;
        if (got_pix !== exp_pix) begin
          value_errors++;
          $display("FAIL %s addr %0d expected %h actual %h",
                   exp_name, exp_addr, exp_pix, got_pix);
        end
      end
    end
  end

  // hard stop if a handshake never finishes
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, run stopped", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    reset   <= 1'b1;
    start   <= 1'b0;
    x0      <= '0;
    y0      <= '0;
    w       <= '0;
    h       <= '0;
    color   <= '0;
    rd_req  <= 1'b0;
    rd_addr <= '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // whole frame in one color sets a known background
    run_fill(0, 0, 16, 8, 12'h5a3, "full_frame");
    check_frame("full_frame");
    run_fill(4, 2, 5, 3, 12'hc0f, "interior");
    check_frame("interior");
    // second rectangle wins where they overlap
    run_fill(1, 1, 6, 4, 12'h111, "overlap_a");
    run_fill(4, 3, 7, 4, 12'hee2, "overlap_b");
    check_frame("overlap");
    // corner near the bottom right, size larger than the frame
    run_fill(13, 6, 20, 10, 12'h7b8, "clip");
    check_frame("clip");
    // empty commands leave the frame alone
    run_fill(2, 2, 0, 5, 12'h0f0, "zero_width");
    run_fill(3, 1, 9, 0, 12'h00f, "zero_height");
    check_frame("empty");

    for (int i = 0; i < 14; i++) begin
      run_fill($random(seed) & 15, $random(seed) & 7, $random(seed) & 31,
               $random(seed) & 15, PB'($random(seed)), $sformatf("random_fill_%0d", i));
      for (int j = 0; j < N_RAND_READS; j++) begin
        read_pixel($random(seed) & (`FB_DEPTH - 1), $sformatf("random_read_%0d", i));
      end
    end

    repeat (2) @(posedge clk);
    assert_fails = u_fb_top.u_fb_assertions.fail_count;
    $display("reads checked %0d, value errors %0d, other errors %0d, assertion failures %0d",
             checks, value_errors, other_errors, assert_fails);
    if (value_errors == 0 && other_errors == 0 && assert_fails == 0 && checks > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
fb_pkg.sv
fb_if.sv
fb_rect_fill.sv
fb_writer.sv
sram_axil.sv
fb_reader.sv
fb_top.sv
fb_assertions.sv
tb_fb_top.sv

//--- Bender.yml
package:
  name: fb_subsystem

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fb_pkg.sv
      - fb_if.sv
      - fb_rect_fill.sv
      - fb_writer.sv
      - sram_axil.sv
      - fb_reader.sv
      - fb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fb_assertions.sv
      - tb_fb_top.sv
